//--- chip8_arch_pkg.sv
// **********************************************************
// CHIP-8 machine state definitions
// Register widths and register file layout used by the core
// **********************************************************

package chip8_arch_pkg;

	// One V register value
	typedef logic [7:0] byte_t;

	// Index into the V register file
	typedef logic [3:0] reg_addr_t;

	// I register, 12-bit address space
	typedef logic [11:0] index_t;

	// V0 to VF
	localparam int NUM_REGS = 16;

	// VF doubles as the carry / borrow / shift-out flag
	localparam reg_addr_t FLAG_REG = 4'hF;

endpackage

//--- chip8_isa_pkg.sv
// **********************************************************
// CHIP-8 instruction set definitions
// Field layout, opcode classes, ALU functions and the
// decoded micro-op that flows from decoder to executor
// **********************************************************

package chip8_isa_pkg;

	// Raw 16-bit instruction word
	typedef logic [15:0] instr_t;

	// Nibble positions inside the instruction word
	localparam int OPCLASS_LSB = 12;
	localparam int X_FIELD_LSB = 8;
	localparam int Y_FIELD_LSB = 4;
	localparam int SUBOP_LSB   = 0;

	// Opcode classes handled by this core
	localparam logic [3:0] OPC_LD_IMM  = 4'h6;
	localparam logic [3:0] OPC_ADD_IMM = 4'h7;
	localparam logic [3:0] OPC_ALU     = 4'h8;
	localparam logic [3:0] OPC_LD_I    = 4'hA;
	localparam logic [3:0] OPC_MISC    = 4'hF;

	// Low byte of Fx1E
	localparam logic [7:0] MISC_ADD_I = 8'h1E;

	// Operation carried by a micro-op
	typedef enum logic [3:0] {
		ALU_PASS,
		ALU_OR,
		ALU_AND,
		ALU_XOR,
		ALU_ADD,
		ALU_SUB,
		ALU_SUBN,
		ALU_SHR,
		ALU_SHL,
		ALU_SET_I,
		ALU_ADD_I
	} alu_func_e;

	// Decoded micro-op
	typedef struct packed {
		alu_func_e                 func;
		chip8_arch_pkg::reg_addr_t x;
		chip8_arch_pkg::reg_addr_t y;
		chip8_arch_pkg::byte_t     imm;
		chip8_arch_pkg::index_t    nnn;
		// Second operand is imm instead of Vy
		logic                      use_imm;
	} uop_t;

endpackage

//--- uop_fifo_if.sv
// **********************************************************
// Micro-op queue interface
// Push side from the decoder, pop side to the executor
// **********************************************************

`timescale 1ns/1ps

interface uop_fifo_if #(
	parameter type payload_t = logic [7:0],
	parameter int  UOP_DEPTH = 4
);

	// Push side
	logic     push;
	payload_t wdata;
	logic     full;

	// Pop side
	logic     pop;
	payload_t rdata;
	logic     empty;

	modport producer (output push, output wdata, input full);
	modport buffer   (input push, input wdata, input pop, output full, output rdata, output empty);
	modport consumer (output pop, input rdata, input empty);

endinterface

//--- chip8_decoder.sv
// **********************************************************
// CHIP-8 instruction decoder
// Maps each strobed instruction word to a micro-op and
// pushes it one cycle later; unknown encodings are dropped
// **********************************************************

`timescale 1ns/1ps

module chip8_decoder (
	input  logic                    cpu_clk,
	input  logic                    rst_n,
	input  logic                    instr_valid,
	input  chip8_isa_pkg::instr_t   instruction,
	uop_fifo_if.producer            uop
);

	logic [3:0]                opclass;
	logic [3:0]                subop;
	chip8_isa_pkg::uop_t       dec_uop;
	logic                      dec_keep;

	// Nibble fields
	assign opclass = instruction[chip8_isa_pkg::OPCLASS_LSB +: 4];
	assign subop   = instruction[chip8_isa_pkg::SUBOP_LSB +: 4];

	always_comb begin
		// Operand fields are copied straight through for every class
		dec_uop         = '0;
		dec_uop.func    = chip8_isa_pkg::ALU_PASS;
		dec_uop.x       = instruction[chip8_isa_pkg::X_FIELD_LSB +: $bits(chip8_arch_pkg::reg_addr_t)];
		dec_uop.y       = instruction[chip8_isa_pkg::Y_FIELD_LSB +: $bits(chip8_arch_pkg::reg_addr_t)];
		dec_uop.imm     = instruction[$bits(chip8_arch_pkg::byte_t)-1:0];
		dec_uop.nnn     = instruction[$bits(chip8_arch_pkg::index_t)-1:0];
		dec_uop.use_imm = 1'b0;
		dec_keep        = 1'b0;

		case (opclass)
			// 6xkk, Vx = kk
			chip8_isa_pkg::OPC_LD_IMM: begin
				dec_uop.use_imm = 1'b1;
				dec_keep        = 1'b1;
			end
			// 7xkk, Vx += kk, no flag
			chip8_isa_pkg::OPC_ADD_IMM: begin
				dec_uop.func    = chip8_isa_pkg::ALU_ADD;
				dec_uop.use_imm = 1'b1;
				dec_keep        = 1'b1;
			end
			// 8xyN register-register group
			chip8_isa_pkg::OPC_ALU: begin
				dec_keep = 1'b1;
				case (subop)
					4'h0: dec_uop.func = chip8_isa_pkg::ALU_PASS;
					4'h1: dec_uop.func = chip8_isa_pkg::ALU_OR;
					4'h2: dec_uop.func = chip8_isa_pkg::ALU_AND;
					4'h3: dec_uop.func = chip8_isa_pkg::ALU_XOR;
					4'h4: dec_uop.func = chip8_isa_pkg::ALU_ADD;
					4'h5: dec_uop.func = chip8_isa_pkg::ALU_SUB;
					4'h6: dec_uop.func = chip8_isa_pkg::ALU_SHR;
					4'h7: dec_uop.func = chip8_isa_pkg::ALU_SUBN;
					4'hE: dec_uop.func = chip8_isa_pkg::ALU_SHL;
					default: dec_keep = 1'b0;
				endcase
			end
			// Annn, I = nnn
			chip8_isa_pkg::OPC_LD_I: begin
				dec_uop.func = chip8_isa_pkg::ALU_SET_I;
				dec_keep     = 1'b1;
			end
			// Fx1E only, I += Vx
			chip8_isa_pkg::OPC_MISC: begin
				if (instruction[7:0] == chip8_isa_pkg::MISC_ADD_I) begin
					dec_uop.func = chip8_isa_pkg::ALU_ADD_I;
					dec_keep     = 1'b1;
				end
			end
			default: dec_keep = 1'b0;
		endcase
	end

	// Push strobe for kept encodings
	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			uop.push <= 1'b0;
		end else begin
			uop.push <= instr_valid && dec_keep;
		end
	end

	// Registered micro-op payload
	always_ff @(posedge cpu_clk) begin
		uop.wdata <= dec_uop;
	end

endmodule

//--- uop_fifo.sv
// **********************************************************
// Micro-op FIFO
// Circular buffer of any payload type; full is raised one
// entry early so a push already in flight always fits
// **********************************************************

`timescale 1ns/1ps

module uop_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  UOP_DEPTH = 4
) (
	input  logic       cpu_clk,
	input  logic       rst_n,
	uop_fifo_if.buffer q
);

	localparam int PTR_W = $clog2(UOP_DEPTH);
	localparam int CNT_W = $clog2(UOP_DEPTH + 1);

	// Depth must be a power of two, 2 to 16, and agree with the interface
	if (UOP_DEPTH < 2 || UOP_DEPTH > 16 || (UOP_DEPTH & (UOP_DEPTH - 1)) != 0 ||
			UOP_DEPTH != q.UOP_DEPTH) begin : g_bad_depth
		$error("uop_fifo: illegal UOP_DEPTH %0d", UOP_DEPTH);
	end

	payload_t         mem [UOP_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_en;
	logic             rd_en;

	// Reserved slot still takes a push while full is high
	assign wr_en = q.push && (count != CNT_W'(UOP_DEPTH));
	assign rd_en = q.pop && (count != '0);

	assign q.full  = (count >= CNT_W'(UOP_DEPTH - 1));
	assign q.empty = (count == '0);
	// Head entry, valid whenever empty is low
	assign q.rdata = mem[rd_ptr];

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap naturally with power-of-two depth
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge cpu_clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= q.wdata;
		end
	end

endmodule

//--- chip8_executor.sv
// **********************************************************
// CHIP-8 executor
// V register file, I register and ALU; retires one
// micro-op per clock and reports every register write
// **********************************************************

`timescale 1ns/1ps

module chip8_executor (
	input  logic                      cpu_clk,
	input  logic                      rst_n,
	uop_fifo_if.consumer              uop,
	output logic                      reg_we,
	output chip8_arch_pkg::reg_addr_t reg_addr,
	output chip8_arch_pkg::byte_t     reg_wdata,
	output logic                      flag_we,
	output chip8_arch_pkg::byte_t     flag_wdata,
	output logic                      i_we,
	output chip8_arch_pkg::index_t    i_wdata
);

	chip8_arch_pkg::byte_t  v_regs [chip8_arch_pkg::NUM_REGS];
	chip8_arch_pkg::index_t i_reg;

	chip8_isa_pkg::uop_t    head;
	logic                   do_pop;
	chip8_arch_pkg::byte_t  vx;
	chip8_arch_pkg::byte_t  vy;
	chip8_arch_pkg::byte_t  operand;
	logic [8:0]             sum;

	logic                   alu_reg_wr;
	logic                   alu_flag_wr;
	logic                   alu_i_wr;
	chip8_arch_pkg::byte_t  alu_res;
	chip8_arch_pkg::byte_t  alu_flag;
	chip8_arch_pkg::index_t alu_i_res;

	// Drain the queue as fast as it fills
	assign do_pop  = !uop.empty;
	assign uop.pop = do_pop;
	assign head    = uop.rdata;

	// Operand fetch
	assign vx      = v_regs[head.x];
	assign vy      = v_regs[head.y];
	assign operand = head.use_imm ? head.imm : vy;
	assign sum     = {1'b0, vx} + {1'b0, operand};

	// ALU
	always_comb begin
		alu_reg_wr  = 1'b1;
		alu_flag_wr = 1'b0;
		alu_i_wr    = 1'b0;
		alu_res     = operand;
		alu_flag    = '0;
		alu_i_res   = i_reg;
		case (head.func)
			chip8_isa_pkg::ALU_PASS: alu_res = operand;
			chip8_isa_pkg::ALU_OR:   alu_res = vx | operand;
			chip8_isa_pkg::ALU_AND:  alu_res = vx & operand;
			chip8_isa_pkg::ALU_XOR:  alu_res = vx ^ operand;
			chip8_isa_pkg::ALU_ADD: begin
				// 7xkk shares this path but leaves VF alone
				alu_res     = sum[7:0];
				alu_flag_wr = !head.use_imm;
				alu_flag    = {7'b0, sum[8]};
			end
			chip8_isa_pkg::ALU_SUB: begin
				alu_res     = vx - vy;
				alu_flag_wr = 1'b1;
				alu_flag    = {7'b0, vx >= vy};
			end
			chip8_isa_pkg::ALU_SUBN: begin
				alu_res     = vy - vx;
				alu_flag_wr = 1'b1;
				alu_flag    = {7'b0, vy >= vx};
			end
			chip8_isa_pkg::ALU_SHR: begin
				alu_res     = vx >> 1;
				alu_flag_wr = 1'b1;
				alu_flag    = {7'b0, vx[0]};
			end
			chip8_isa_pkg::ALU_SHL: begin
				alu_res     = vx << 1;
				alu_flag_wr = 1'b1;
				alu_flag    = {7'b0, vx[7]};
			end
			chip8_isa_pkg::ALU_SET_I: begin
				alu_reg_wr = 1'b0;
				alu_i_wr   = 1'b1;
				alu_i_res  = head.nnn;
			end
			chip8_isa_pkg::ALU_ADD_I: begin
				// Wraps at 12 bits
				alu_reg_wr = 1'b0;
				alu_i_wr   = 1'b1;
				alu_i_res  = i_reg + {4'b0, vx};
			end
			default: alu_reg_wr = 1'b0;
		endcase
	end

	// Architectural state and write strobes
	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < chip8_arch_pkg::NUM_REGS; i++) begin
				v_regs[i] <= '0;
			end
			i_reg   <= '0;
			reg_we  <= 1'b0;
			flag_we <= 1'b0;
			i_we    <= 1'b0;
		end else begin
			reg_we  <= do_pop && alu_reg_wr;
			flag_we <= do_pop && alu_flag_wr;
			i_we    <= do_pop && alu_i_wr;
			if (do_pop && alu_reg_wr) begin
				v_regs[head.x] <= alu_res;
			end
			// Last assignment wins, so VF beats Vx when x is 15
			if (do_pop && alu_flag_wr) begin
				v_regs[chip8_arch_pkg::FLAG_REG] <= alu_flag;
			end
			if (do_pop && alu_i_wr) begin
				i_reg <= alu_i_res;
			end
		end
	end

	// Write port data, qualified by the strobes above
	always_ff @(posedge cpu_clk) begin
		reg_addr   <= head.x;
		reg_wdata  <= alu_res;
		flag_wdata <= alu_flag;
		i_wdata    <= alu_i_res;
	end

endmodule

//--- chip8_core.sv
// **********************************************************
// CHIP-8 data-path core
// Decoder, micro-op FIFO and executor in a row
// **********************************************************

`timescale 1ns/1ps

module chip8_core #(
	parameter int UOP_DEPTH = 4
) (
	input  logic                      cpu_clk,
	input  logic                      rst_n,
	input  logic                      instr_valid,
	input  chip8_isa_pkg::instr_t     instruction,
	output logic                      instr_full,
	output logic                      reg_we,
	output chip8_arch_pkg::reg_addr_t reg_addr,
	output chip8_arch_pkg::byte_t     reg_wdata,
	output logic                      flag_we,
	output chip8_arch_pkg::byte_t     flag_wdata,
	output logic                      i_we,
	output chip8_arch_pkg::index_t    i_wdata
);

	// Queue between decode and execute
	uop_fifo_if #(
		.payload_t (chip8_isa_pkg::uop_t),
		.UOP_DEPTH (UOP_DEPTH)
	) uop_q ();

	// Back-pressure to the instruction source
	assign instr_full = uop_q.full;

	chip8_decoder decoder_i (
		.cpu_clk     (cpu_clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instruction (instruction),
		.uop         (uop_q.producer)
	);

	uop_fifo #(
		.payload_t (chip8_isa_pkg::uop_t),
		.UOP_DEPTH (UOP_DEPTH)
	) fifo_i (
		.cpu_clk (cpu_clk),
		.rst_n   (rst_n),
		.q       (uop_q.buffer)
	);

	chip8_executor executor_i (
		.cpu_clk    (cpu_clk),
		.rst_n      (rst_n),
		.uop        (uop_q.consumer),
		.reg_we     (reg_we),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.flag_we    (flag_we),
		.flag_wdata (flag_wdata),
		.i_we       (i_we),
		.i_wdata    (i_wdata)
	);

endmodule

//--- chip8_core_props.sv
// **********************************************************
// CHIP-8 core protocol assertions
// Strobe and full-level rules, bound into chip8_core
// **********************************************************

`timescale 1ns/1ps

module chip8_core_props (
	input logic cpu_clk,
	input logic rst_n,
	input logic instr_valid,
	input logic instr_full,
	input logic reg_we,
	input logic flag_we,
	input logic i_we
);

	// Source reacts to the full level of the previous cycle
	a_no_strobe_when_full: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		instr_valid |-> !$past(instr_full))
		else $error("instruction strobed while instr_full was high");

	// Quiet write ports through reset and the cycle after it
	a_quiet_after_reset: assert property (@(posedge cpu_clk)
		!rst_n |=> !(reg_we || flag_we || i_we))
		else $error("write strobe during reset or right after it");

	// VF is only written alongside a V write
	a_flag_with_reg: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		flag_we |-> reg_we)
		else $error("flag_we without reg_we");

endmodule

bind chip8_core chip8_core_props props_i (
	.cpu_clk     (cpu_clk),
	.rst_n       (rst_n),
	.instr_valid (instr_valid),
	.instr_full  (instr_full),
	.reg_we      (reg_we),
	.flag_we     (flag_we),
	.i_we        (i_we)
);

//--- tb_chip8_core.sv
// **********************************************************
// Testbench for the CHIP-8 data-path core
// LFSR stimulus, reference register model and a write
// checker that compares every strobe against the model
// **********************************************************

`timescale 1ns/1ps

module tb_chip8_core;

	localparam int          CLK_PERIOD    = 40;
	localparam int          RESET_CYCLES  = 8;
	// Depth 2 lets a short burst reach the full level
	localparam int          FIFO_DEPTH    = 2;
	localparam logic [31:0] LFSR_SEED     = 32'h0fe1a51b;
	// x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS     = 32'h80200003;
	localparam int          FULL_TIMEOUT  = 50;
	localparam int          DRAIN_TIMEOUT = 200;
	localparam int          LAT_TIMEOUT   = 20;
	localparam int          NUM_ALU_TESTS = 60;
	localparam int          NUM_MIX_TESTS = 80;
	localparam int          BURST_LEN     = 24;

	logic        cpu_clk;
	logic        rst_n;
	logic        instr_valid;
	logic [15:0] instruction;
	logic        instr_full;
	logic        reg_we;
	logic [3:0]  reg_addr;
	logic [7:0]  reg_wdata;
	logic        flag_we;
	logic [7:0]  flag_wdata;
	logic        i_we;
	logic [11:0] i_wdata;

	// Model state and expected write per retired instruction
	logic [7:0]  model_v [16];
	logic [11:0] model_i;
	logic [34:0] exp_q [$];
	logic [31:0] lfsr_state;
	logic        saw_full;

	chip8_core #(
		.UOP_DEPTH (FIFO_DEPTH)
	) dut_i (
		.cpu_clk     (cpu_clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instruction (instruction),
		.instr_full  (instr_full),
		.reg_we      (reg_we),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.flag_we     (flag_we),
		.flag_wdata  (flag_wdata),
		.i_we        (i_we),
		.i_wdata     (i_wdata)
	);

	initial begin
		cpu_clk = 1'b0;
		forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
	end

	task automatic stop_with_failure();
		$display("FAIL: see errors above");
		$fatal(1, "stopping at first error");
	endtask

	task automatic abort_run(input string what);
		$display("ERROR at %0t: %s", $time, what);
		stop_with_failure();
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0t: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	// Galois step, one call per random bit
	function automatic logic lfsr_step();
		logic lsb;
		lsb        = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ LFSR_TAPS;
		end
		return lsb;
	endfunction

	function automatic logic [3:0] rand_nib();
		logic [3:0] v;
		v = '0;
		for (int b = 0; b < 4; b++) begin
			v = {v[2:0], lfsr_step()};
		end
		return v;
	endfunction

	function automatic logic [7:0] rand_byte();
		return {rand_nib(), rand_nib()};
	endfunction

	// Random nibble onto the kept 8xy sub-opcodes
	function automatic logic [3:0] pick_subop(input logic [3:0] r);
		if (!r[3]) begin
			return r;
		end
		return (r[2:0] >= 3'h6) ? 4'hE : {1'b0, r[2:0]};
	endfunction

	// Data fields are don't-care while their strobe is low
	function automatic logic [34:0] pack_write(input logic rwe, input logic [3:0] addr,
			input logic [7:0] rdata, input logic fwe, input logic [7:0] fdata,
			input logic iwe, input logic [11:0] idata);
		return {rwe, rwe ? addr : 4'h0, rwe ? rdata : 8'h00,
			fwe, fwe ? fdata : 8'h00, iwe, iwe ? idata : 12'h000};
	endfunction

	// Reference model of the kept ISA
	function automatic void model_instr(input logic [15:0] ins);
		logic [3:0]  x;
		logic [3:0]  y;
		logic [7:0]  kk;
		logic [7:0]  vx;
		logic [7:0]  vy;
		logic [7:0]  res;
		logic [7:0]  flg;
		logic [8:0]  s;
		logic [11:0] inew;
		logic        rwe;
		logic        fwe;
		logic        iwe;
		x    = ins[11:8];
		y    = ins[7:4];
		kk   = ins[7:0];
		vx   = model_v[x];
		vy   = model_v[y];
		s    = {1'b0, vx} + {1'b0, vy};
		res  = 8'h00;
		flg  = 8'h00;
		inew = model_i;
		rwe  = 1'b0;
		fwe  = 1'b0;
		iwe  = 1'b0;
		case (ins[15:12])
			4'h6: begin
				rwe = 1'b1;
				res = kk;
			end
			// Wraps, VF untouched
			4'h7: begin
				rwe = 1'b1;
				res = vx + kk;
			end
			4'h8: begin
				rwe = 1'b1;
				case (ins[3:0])
					4'h0: res = vy;
					4'h1: res = vx | vy;
					4'h2: res = vx & vy;
					4'h3: res = vx ^ vy;
					4'h4: {fwe, res, flg} = {1'b1, s[7:0], 7'b0, s[8]};
					4'h5: {fwe, res, flg} = {1'b1, vx - vy, 7'b0, vx >= vy};
					4'h6: {fwe, res, flg} = {1'b1, vx >> 1, 7'b0, vx[0]};
					4'h7: {fwe, res, flg} = {1'b1, vy - vx, 7'b0, vy >= vx};
					4'hE: {fwe, res, flg} = {1'b1, vx << 1, 7'b0, vx[7]};
					default: rwe = 1'b0;
				endcase
			end
			4'hA: begin
				iwe  = 1'b1;
				inew = ins[11:0];
			end
			4'hF: begin
				iwe  = (kk == 8'h1E);
				inew = model_i + {4'h0, vx};
			end
			default: rwe = 1'b0;
		endcase
		if (!(rwe || iwe)) begin
			return;
		end
		if (rwe) begin
			model_v[x] = res;
		end
		// VF write lands last
		if (fwe) begin
			model_v[15] = flg;
		end
		if (iwe) begin
			model_i = inew;
		end
		exp_q.push_back(pack_write(rwe, x, res, fwe, flg, iwe, inew));
	endfunction

	// Strobe one instruction once instr_full is seen low
	task automatic send_instr(input logic [15:0] ins);
		int waited;
		waited = 0;
		@(negedge cpu_clk);
		while (instr_full) begin
			saw_full = 1'b1;
			if (waited == FULL_TIMEOUT) begin
				abort_run("timeout waiting for instr_full to fall");
			end
			waited++;
			@(posedge cpu_clk);
			instr_valid <= 1'b0;
			@(negedge cpu_clk);
		end
		@(posedge cpu_clk);
		instr_valid <= 1'b1;
		instruction <= ins;
		model_instr(ins);
	endtask

	task automatic go_idle();
		@(posedge cpu_clk);
		instr_valid <= 1'b0;
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			if (waited == DRAIN_TIMEOUT) begin
				abort_run("timeout waiting for outstanding register writes");
			end
			waited++;
			@(negedge cpu_clk);
		end
	endtask

	// Compare every write strobe against the head of the model queue
	always @(negedge cpu_clk) begin
		if (rst_n && (reg_we || flag_we || i_we)) begin
			if (exp_q.size() == 0) begin
				abort_run("register write with no instruction outstanding");
			end else begin
				check_value("register write", 64'(pack_write(reg_we, reg_addr, reg_wdata,
					flag_we, flag_wdata, i_we, i_wdata)), 64'(exp_q.pop_front()));
			end
		end
	end

	initial begin
		logic [3:0] x;
		int         lat;
		logic       seen;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instruction = 16'h0000;
		lfsr_state  = LFSR_SEED;
		saw_full    = 1'b0;
		model_i     = 12'h000;
		for (int r = 0; r < 16; r++) begin
			model_v[r] = 8'h00;
		end
		repeat (RESET_CYCLES) @(posedge cpu_clk);
		rst_n <= 1'b1;

		// Idle core after reset
		repeat (6) begin
			@(negedge cpu_clk);
			check_value("idle write strobes", 64'({reg_we, flag_we, i_we}), 64'(0));
			check_value("idle instr_full", 64'(instr_full), 64'(0));
		end

		// LD and ADD immediate on every register, then a forced wrap
		for (int r = 0; r < 16; r++) begin
			send_instr({4'h6, 4'(r), rand_byte()});
			send_instr({4'h7, 4'(r), rand_byte()});
		end
		send_instr(16'h62F0);
		send_instr(16'h7220);
		go_idle();
		wait_drained();

		// Register-register group, random then carry into VF with x = 15
		for (int n = 0; n < NUM_ALU_TESTS; n++) begin
			send_instr({4'h8, rand_nib(), rand_nib(), pick_subop(rand_nib())});
		end
		send_instr(16'h6FF0);
		send_instr(16'h6130);
		send_instr(16'h8F14);
		send_instr(16'h8FE5);
		go_idle();
		wait_drained();

		// I register, 0xFF0 + 0xFF wraps to 0x0EF
		send_instr(16'h60FF);
		send_instr(16'hAFF0);
		send_instr(16'hF01E);
		for (int k = 0; k < 8; k++) begin
			x = rand_nib();
			send_instr({4'hA, rand_nib(), rand_byte()});
			send_instr({4'hF, x, 8'h1E});
		end
		go_idle();
		wait_drained();

		// Fully random words, most of them outside the kept set
		for (int n = 0; n < NUM_MIX_TESTS; n++) begin
			send_instr({rand_byte(), rand_byte()});
		end
		go_idle();
		wait_drained();

		// Back-to-back burst against the full level
		saw_full = 1'b0;
		for (int n = 0; n < BURST_LEN; n++) begin
			send_instr({4'h8, rand_nib(), rand_nib(), pick_subop(rand_nib())});
		end
		go_idle();
		wait_drained();
		check_value("instr_full raised by burst", 64'(saw_full), 64'(1));

		// Lone instruction on an idle core
		send_instr(16'h6A5C);
		lat  = 0;
		seen = 1'b0;
		while (!seen) begin
			if (lat == LAT_TIMEOUT) begin
				abort_run("timeout waiting for the lone instruction to retire");
			end
			@(posedge cpu_clk);
			instr_valid <= 1'b0;
			lat++;
			@(negedge cpu_clk);
			seen = reg_we || flag_we || i_we;
		end
		check_value("lone instruction latency", 64'(lat), 64'(3));
		wait_drained();

		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- files.f
chip8_arch_pkg.sv
chip8_isa_pkg.sv
uop_fifo_if.sv
chip8_decoder.sv
uop_fifo.sv
chip8_executor.sv
chip8_core.sv
chip8_core_props.sv
tb_chip8_core.sv

//--- Makefile
# Verilator flow for the CHIP-8 data-path core
VERILATOR  := verilator
TOP        := tb_chip8_core
FILELIST   := files.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := FAIL: see errors above
PASS_MSG   := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG) || ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
